// ==== soc_bus_top.f ====
src/bus_pkg.sv
src/bus_arbiter.sv
src/axi_bus.sv
src/led_slave.sv
src/default_slave.sv
src/btn_master.sv
src/soc_bus_top.sv
verif/soc_bus_tb.sv

// ==== verif/soc_bus_input.txt ====
# columns: test_name operation address data strobe exp_data exp_resp, all numbers hex
# operation is write, read or button; a button vector puts data on btn
led_wr     write  20000000 a5a5c3c9 f 00000000 0
led_rd     read   20000000 00000000 0 a5a5c3c9 0
scr_wr     write  20000004 11223344 f 00000000 0
scr_strb   write  20000004 aabbccdd 5 00000000 0
scr_rd1    read   20000004 00000000 0 11bb33dd 0
scr_strb2  write  20000004 ffeeddcc a 00000000 0
scr_rd2    read   20000004 00000000 0 ffbbdddd 0
unmap_wr   write  30000000 deadbeef f 00000000 3
unmap_rd   read   30000010 00000000 0 00000000 3
unmap_rd0  read   00000000 00000000 0 00000000 3
bad_wr     write  20000008 12345678 f 00000000 2
bad_rd     read   20000008 00000000 0 00000000 2
led_keep   read   20000000 00000000 0 a5a5c3c9 0
scr_keep   read   20000004 00000000 0 ffbbdddd 0
btn_a      button 00000000 0000000a 0 0000000a 0
btn_rd     read   20000004 00000000 0 0000000a 0
btn_5      button 00000000 00000005 0 00000005 0
btn_rd5    read   20000004 00000000 0 00000005 0
led_wr2    write  20000000 00000036 3 00000000 0
led_rd2    read   20000000 00000000 0 a5a50036 0
unmap_hi   write  f0000004 00000001 f 00000000 3

// ==== verif/soc_bus_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_bus_tb;

    localparam int CLK_PERIOD     = 8;
    localparam int MAX_VEC        = 64;
    localparam int CYCLES_PER_VEC = 200;

    logic sys_clk;
    logic rst_n;
    bus_pkg::btn_t  btn;
    bus_pkg::led_t  led;
    bus_pkg::addr_t m0_wr_addr, m0_rd_addr;
    bus_pkg::data_t m0_wr_data, m0_rd_data;
    bus_pkg::strb_t m0_wr_strb;
    bus_pkg::resp_t m0_wr_resp, m0_rd_resp;
    logic m0_wr_valid, m0_wr_ready, m0_wr_resp_valid, m0_wr_resp_ready;
    logic m0_rd_valid, m0_rd_ready, m0_rd_resp_valid, m0_rd_resp_ready;

    logic [8*16-1:0] vec_name [MAX_VEC];
    logic [8*8-1:0]  vec_op   [MAX_VEC];
    bus_pkg::addr_t  vec_addr [MAX_VEC];
    bus_pkg::data_t  vec_data [MAX_VEC];
    bus_pkg::strb_t  vec_strb [MAX_VEC];
    bus_pkg::data_t  vec_exp  [MAX_VEC];
    bus_pkg::resp_t  vec_resp [MAX_VEC];

    int num_vec;
    logic loaded;
    int errors, checks;
    int wr_count, rd_count, wr_rsp_seen, rd_rsp_seen;
    logic [15:0] lfsr;

    soc_bus_top UUT (.*);

    initial begin
        sys_clk = 1'b0;
        forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
    end

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    // random response ready with one lfsr step per bit
    initial begin
        lfsr = 16'd61413;
        m0_wr_resp_ready = 1'b0;
        m0_rd_resp_ready = 1'b0;
        forever begin
            @(posedge sys_clk);
            #1;
            m0_wr_resp_ready = lfsr[0];
            lfsr = lfsr_next(lfsr);
            m0_rd_resp_ready = lfsr[0];
            lfsr = lfsr_next(lfsr);
        end
    end

    always @(negedge sys_clk) begin
        if (rst_n && m0_wr_resp_valid && m0_wr_resp_ready) wr_rsp_seen++;
        if (rst_n && m0_rd_resp_valid && m0_rd_resp_ready) rd_rsp_seen++;
    end

    task automatic compare_value(input logic [8*16-1:0] name, input logic [8*8-1:0] what,
                                 input logic [31:0] expected, input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("Mismatch %0s %0s: expected %h, actual %h", name, what, expected, actual);
        end
    endtask

    // response must stay up and unchanged until ready
    task automatic wait_wr_resp(output bus_pkg::resp_t resp);
        logic seen;
        logic done;
        bus_pkg::resp_t held;
        seen = 1'b0;
        done = 1'b0;
        held = '0;
        while (!done) begin
            @(negedge sys_clk);
            assert (!seen || m0_wr_resp_valid) else begin
                errors++;
                $display("write response valid dropped before it was accepted");
            end
            if (m0_wr_resp_valid) begin
                assert (!seen || m0_wr_resp === held) else begin
                    errors++;
                    $display("write response changed while held under back-pressure");
                end
                seen = 1'b1;
                held = m0_wr_resp;
                done = m0_wr_resp_ready;
            end
        end
        resp = m0_wr_resp;
    endtask

    task automatic wait_rd_resp(output bus_pkg::data_t data, output bus_pkg::resp_t resp);
        logic seen;
        logic done;
        logic [33:0] held;
        seen = 1'b0;
        done = 1'b0;
        held = '0;
        while (!done) begin
            @(negedge sys_clk);
            assert (!seen || m0_rd_resp_valid) else begin
                errors++;
                $display("read response valid dropped before it was accepted");
            end
            if (m0_rd_resp_valid) begin
                assert (!seen || {m0_rd_resp, m0_rd_data} === held) else begin
                    errors++;
                    $display("read response changed while held under back-pressure");
                end
                seen = 1'b1;
                held = {m0_rd_resp, m0_rd_data};
                done = m0_rd_resp_ready;
            end
        end
        data = m0_rd_data;
        resp = m0_rd_resp;
    endtask

    task automatic run_write(input bus_pkg::addr_t addr, input bus_pkg::data_t data,
                             input bus_pkg::strb_t strb, output bus_pkg::resp_t resp);
        @(posedge sys_clk);
        #1;
        m0_wr_addr  = addr;
        m0_wr_data  = data;
        m0_wr_strb  = strb;
        m0_wr_valid = 1'b1;
        @(negedge sys_clk);
        while (!m0_wr_ready) @(negedge sys_clk);
        @(posedge sys_clk);
        #1;
        m0_wr_valid = 1'b0;
        wait_wr_resp(resp);
    endtask

    task automatic run_read(input bus_pkg::addr_t addr, output bus_pkg::data_t data,
                            output bus_pkg::resp_t resp);
        @(posedge sys_clk);
        #1;
        m0_rd_addr  = addr;
        m0_rd_valid = 1'b1;
        @(negedge sys_clk);
        while (!m0_rd_ready) @(negedge sys_clk);
        @(posedge sys_clk);
        #1;
        m0_rd_valid = 1'b0;
        wait_rd_resp(data, resp);
    endtask

    task automatic press_button(input bus_pkg::btn_t value, output bus_pkg::btn_t seen);
        int n;
        @(posedge sys_clk);
        #1;
        btn = value;
        n = 0;
        @(negedge sys_clk);
        while (led[7:4] !== value && n < CYCLES_PER_VEC / 2) begin
            @(negedge sys_clk);
            n++;
        end
        seen = led[7:4];
        @(posedge sys_clk);
        #1;
        btn = '0;
        repeat (4) @(posedge sys_clk);      // release has to pass the synchroniser
    endtask

    initial begin
        int fd;
        int r;
        logic [8*120-1:0] line_buf;
        logic [8*16-1:0] name;
        logic [8*8-1:0] op;
        bus_pkg::addr_t addr;
        bus_pkg::data_t wdata, exp_data, rdata;
        bus_pkg::strb_t strb;
        bus_pkg::resp_t exp_resp, resp;
        bus_pkg::btn_t nib;

        errors = 0;
        checks = 0;
        num_vec = 0;
        loaded = 1'b0;
        wr_count = 0;
        rd_count = 0;
        wr_rsp_seen = 0;
        rd_rsp_seen = 0;
        rst_n = 1'b0;
        btn = '0;
        m0_wr_addr = '0;
        m0_wr_data = '0;
        m0_wr_strb = '0;
        m0_wr_valid = 1'b0;
        m0_rd_addr = '0;
        m0_rd_valid = 1'b0;

        fd = $fopen("verif/soc_bus_input.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open verif/soc_bus_input.txt");
        end else begin
            while (!$feof(fd)) begin
                r = $fgets(line_buf, fd);
                if (r > 0) begin
                    r = $sscanf(line_buf, "%s %s %h %h %h %h %h",
                                name, op, addr, wdata, strb, exp_data, exp_resp);
                    if (r == 7 && num_vec < MAX_VEC) begin     // comments give fewer fields
                        vec_name[num_vec] = name;
                        vec_op[num_vec]   = op;
                        vec_addr[num_vec] = addr;
                        vec_data[num_vec] = wdata;
                        vec_strb[num_vec] = strb;
                        vec_exp[num_vec]  = exp_data;
                        vec_resp[num_vec] = exp_resp;
                        num_vec++;
                    end
                end
            end
            $fclose(fd);
        end
        loaded = 1'b1;

        repeat (4) @(posedge sys_clk);
        #1;
        rst_n = 1'b1;

        // bus comes out of reset idle with the leds dark
        @(negedge sys_clk);
        compare_value("reset", "led", 32'h0, led);
        compare_value("reset", "handshk", 32'h0,
                      {m0_wr_ready, m0_wr_resp_valid, m0_rd_ready, m0_rd_resp_valid});

        for (int i = 0; i < num_vec; i++) begin
            if (vec_op[i] == "write") begin
                wr_count++;
                run_write(vec_addr[i], vec_data[i], vec_strb[i], resp);
                compare_value(vec_name[i], "resp", vec_resp[i], resp);
            end else if (vec_op[i] == "read") begin
                rd_count++;
                run_read(vec_addr[i], rdata, resp);
                compare_value(vec_name[i], "resp", vec_resp[i], resp);
                compare_value(vec_name[i], "data", vec_exp[i], rdata);
                // led pins follow the low nibble of the led register
                if (vec_addr[i] == bus_pkg::LED_BASE + bus_pkg::LED_REG_OFFSET &&
                    vec_resp[i] == bus_pkg::RESP_OKAY) begin
                    compare_value(vec_name[i], "led_lo", vec_exp[i][3:0], led[3:0]);
                end
            end else if (vec_op[i] == "button") begin
                press_button(vec_data[i][3:0], nib);
                compare_value(vec_name[i], "led_hi", vec_exp[i][3:0], nib);
            end else begin
                errors++;
                $display("vector %0d has an unknown operation", i);
            end
        end

        repeat (2) @(posedge sys_clk);
        compare_value("resp_count", "writes", wr_count, wr_rsp_seen);
        compare_value("resp_count", "reads", rd_count, rd_rsp_seen);

        $display("vectors: %0d, checks: %0d, errors: %0d", num_vec, checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // watchdog budget scales with the vector count
    initial begin
        wait (loaded);
        repeat ((num_vec + 1) * CYCLES_PER_VEC) @(posedge sys_clk);
        $display("timeout: run did not finish in %0d cycles, checks: %0d, errors: %0d",
                 (num_vec + 1) * CYCLES_PER_VEC, checks, errors);
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/soc_bus_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_bus_top (
    input  wire                 sys_clk,
    input  wire                 rst_n,
    input  wire bus_pkg::btn_t  btn,
    output wire bus_pkg::led_t  led,
    input  wire bus_pkg::addr_t m0_wr_addr,
    input  wire bus_pkg::data_t m0_wr_data,
    input  wire bus_pkg::strb_t m0_wr_strb,
    input  wire                 m0_wr_valid,
    output wire                 m0_wr_ready,
    output wire bus_pkg::resp_t m0_wr_resp,
    output wire                 m0_wr_resp_valid,
    input  wire                 m0_wr_resp_ready,
    input  wire bus_pkg::addr_t m0_rd_addr,
    input  wire                 m0_rd_valid,
    output wire                 m0_rd_ready,
    output wire bus_pkg::data_t m0_rd_data,
    output wire bus_pkg::resp_t m0_rd_resp,
    output wire                 m0_rd_resp_valid,
    input  wire                 m0_rd_resp_ready
);

    // button master
    wire bus_pkg::addr_t m1_wr_addr, m1_rd_addr;
    wire bus_pkg::data_t m1_wr_data, m1_rd_data;
    wire bus_pkg::strb_t m1_wr_strb;
    wire bus_pkg::resp_t m1_wr_resp, m1_rd_resp;
    wire m1_wr_valid, m1_wr_ready, m1_wr_resp_valid, m1_wr_resp_ready;
    wire m1_rd_valid, m1_rd_ready, m1_rd_resp_valid, m1_rd_resp_ready;

    // led slave
    wire bus_pkg::addr_t s0_wr_addr, s0_rd_addr;
    wire bus_pkg::data_t s0_wr_data, s0_rd_data;
    wire bus_pkg::strb_t s0_wr_strb;
    wire bus_pkg::resp_t s0_wr_resp, s0_rd_resp;
    wire s0_wr_valid, s0_wr_ready, s0_wr_resp_valid, s0_wr_resp_ready;
    wire s0_rd_valid, s0_rd_ready, s0_rd_resp_valid, s0_rd_resp_ready;

    // default slave, payload not needed
    wire bus_pkg::data_t s1_rd_data;
    wire bus_pkg::resp_t s1_wr_resp, s1_rd_resp;
    wire s1_wr_valid, s1_wr_ready, s1_wr_resp_valid, s1_wr_resp_ready;
    wire s1_rd_valid, s1_rd_ready, s1_rd_resp_valid, s1_rd_resp_ready;

    btn_master u_btn (
        .sys_clk(sys_clk), .rst_n(rst_n), .btn(btn), .recv(led[7:4]),
        .wr_addr(m1_wr_addr), .wr_data(m1_wr_data), .wr_strb(m1_wr_strb),
        .wr_valid(m1_wr_valid), .wr_ready(m1_wr_ready),
        .wr_resp(m1_wr_resp), .wr_resp_valid(m1_wr_resp_valid),
        .wr_resp_ready(m1_wr_resp_ready),
        .rd_addr(m1_rd_addr), .rd_valid(m1_rd_valid), .rd_ready(m1_rd_ready),
        .rd_data(m1_rd_data), .rd_resp(m1_rd_resp),
        .rd_resp_valid(m1_rd_resp_valid), .rd_resp_ready(m1_rd_resp_ready)
    );

    axi_bus u_bus (.*);

    led_slave u_led (
        .sys_clk(sys_clk), .rst_n(rst_n), .led(led[3:0]),
        .wr_addr(s0_wr_addr), .wr_data(s0_wr_data), .wr_strb(s0_wr_strb),
        .wr_valid(s0_wr_valid), .wr_ready(s0_wr_ready),
        .wr_resp(s0_wr_resp), .wr_resp_valid(s0_wr_resp_valid),
        .wr_resp_ready(s0_wr_resp_ready),
        .rd_addr(s0_rd_addr), .rd_valid(s0_rd_valid), .rd_ready(s0_rd_ready),
        .rd_data(s0_rd_data), .rd_resp(s0_rd_resp),
        .rd_resp_valid(s0_rd_resp_valid), .rd_resp_ready(s0_rd_resp_ready)
    );

    default_slave u_default (
        .sys_clk(sys_clk), .rst_n(rst_n),
        .wr_valid(s1_wr_valid), .wr_ready(s1_wr_ready),
        .wr_resp(s1_wr_resp), .wr_resp_valid(s1_wr_resp_valid),
        .wr_resp_ready(s1_wr_resp_ready),
        .rd_valid(s1_rd_valid), .rd_ready(s1_rd_ready),
        .rd_data(s1_rd_data), .rd_resp(s1_rd_resp),
        .rd_resp_valid(s1_rd_resp_valid), .rd_resp_ready(s1_rd_resp_ready)
    );

endmodule

`default_nettype wire

// ==== src/btn_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module btn_master (
    input  wire                 sys_clk,
    input  wire                 rst_n,
    input  wire bus_pkg::btn_t  btn,
    output logic [3:0]          recv,
    output bus_pkg::addr_t      wr_addr,
    output bus_pkg::data_t      wr_data,
    output bus_pkg::strb_t      wr_strb,
    output logic                wr_valid,
    input  wire                 wr_ready,
    input  wire bus_pkg::resp_t wr_resp,
    input  wire                 wr_resp_valid,
    output logic                wr_resp_ready,
    output bus_pkg::addr_t      rd_addr,
    output logic                rd_valid,
    input  wire                 rd_ready,
    input  wire bus_pkg::data_t rd_data,
    input  wire bus_pkg::resp_t rd_resp,
    input  wire                 rd_resp_valid,
    output logic                rd_resp_ready
);

    bus_pkg::btn_state_t state;
    bus_pkg::btn_t btn_meta, btn_sync, btn_prev;
    bus_pkg::btn_t btn_val;     // value being sent
    logic press;

    assign press = |(btn_sync & ~btn_prev);      // any bit going high

    // always the scratch register of the led slave
    assign wr_addr       = bus_pkg::LED_BASE + bus_pkg::SCRATCH_OFFSET;
    assign rd_addr       = bus_pkg::LED_BASE + bus_pkg::SCRATCH_OFFSET;
    assign wr_data       = bus_pkg::data_t'(btn_val);
    assign wr_strb       = 4'hF;
    assign wr_valid      = (state == bus_pkg::BTN_WRITE);
    assign wr_resp_ready = (state == bus_pkg::BTN_WAIT_B);
    assign rd_valid      = (state == bus_pkg::BTN_READ);
    assign rd_resp_ready = (state == bus_pkg::BTN_WAIT_R);

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            state    <= bus_pkg::BTN_IDLE;
            btn_meta <= '0;
            btn_sync <= '0;
            btn_prev <= '0;
            recv     <= '0;
        end else begin
            btn_meta <= btn;
            btn_sync <= btn_meta;
            btn_prev <= btn_sync;
            case (state)
                bus_pkg::BTN_IDLE: begin
                    if (press) begin
                        state <= bus_pkg::BTN_WRITE;
                    end
                end
                bus_pkg::BTN_WRITE: begin
                    if (wr_ready) begin
                        state <= bus_pkg::BTN_WAIT_B;
                    end
                end
                bus_pkg::BTN_WAIT_B: begin
                    if (wr_resp_valid) begin
                        // no readback after a failed write
                        state <= (wr_resp == bus_pkg::RESP_OKAY) ? bus_pkg::BTN_READ
                                                                  : bus_pkg::BTN_IDLE;
                    end
                end
                bus_pkg::BTN_READ: begin
                    if (rd_ready) begin
                        state <= bus_pkg::BTN_WAIT_R;
                    end
                end
                bus_pkg::BTN_WAIT_R: begin
                    if (rd_resp_valid) begin
                        state <= bus_pkg::BTN_IDLE;
                        if (rd_resp == bus_pkg::RESP_OKAY) begin
                            recv <= rd_data[3:0];
                        end
                    end
                end
                default: state <= bus_pkg::BTN_IDLE;
            endcase
        end
    end

    // presses outside idle are dropped
    always_ff @(posedge sys_clk) begin
        if (state == bus_pkg::BTN_IDLE && press) begin
            btn_val <= btn_sync;
        end
    end

endmodule

`default_nettype wire

// ==== src/default_slave.sv ====
`timescale 1ns/1ps
`default_nettype none

module default_slave (
    input  wire            sys_clk,
    input  wire            rst_n,
    input  wire            wr_valid,
    output logic           wr_ready,
    output bus_pkg::resp_t wr_resp,
    output logic           wr_resp_valid,
    input  wire            wr_resp_ready,
    input  wire            rd_valid,
    output logic           rd_ready,
    output bus_pkg::data_t rd_data,
    output bus_pkg::resp_t rd_resp,
    output logic           rd_resp_valid,
    input  wire            rd_resp_ready
);

    // nothing lives here
    assign wr_resp = bus_pkg::RESP_DECERR;
    assign rd_resp = bus_pkg::RESP_DECERR;
    assign rd_data = '0;

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            wr_ready      <= 1'b0;
            wr_resp_valid <= 1'b0;
            rd_ready      <= 1'b0;
            rd_resp_valid <= 1'b0;
        end else begin
            wr_ready <= wr_valid & ~wr_ready & ~wr_resp_valid;
            rd_ready <= rd_valid & ~rd_ready & ~rd_resp_valid;
            if (wr_valid && wr_ready) begin
                wr_resp_valid <= 1'b1;
            end else if (wr_resp_ready) begin
                wr_resp_valid <= 1'b0;      // held under back-pressure
            end
            if (rd_valid && rd_ready) begin
                rd_resp_valid <= 1'b1;
            end else if (rd_resp_ready) begin
                rd_resp_valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/led_slave.sv ====
`timescale 1ns/1ps
`default_nettype none

module led_slave (
    input  wire                 sys_clk,
    input  wire                 rst_n,
    input  wire bus_pkg::addr_t wr_addr,
    input  wire bus_pkg::data_t wr_data,
    input  wire bus_pkg::strb_t wr_strb,
    input  wire                 wr_valid,
    output logic                wr_ready,
    output bus_pkg::resp_t      wr_resp,
    output logic                wr_resp_valid,
    input  wire                 wr_resp_ready,
    input  wire bus_pkg::addr_t rd_addr,
    input  wire                 rd_valid,
    output logic                rd_ready,
    output bus_pkg::data_t      rd_data,
    output bus_pkg::resp_t      rd_resp,
    output logic                rd_resp_valid,
    input  wire                 rd_resp_ready,
    output logic [3:0]          led
);

    bus_pkg::data_t led_reg;
    bus_pkg::data_t scratch_reg;
    bus_pkg::addr_t wr_off, rd_off;
    logic wr_fire, rd_fire;
    logic wr_led, wr_scr, rd_led, rd_scr;

    function automatic bus_pkg::data_t merge(
        input bus_pkg::data_t old_val,
        input bus_pkg::data_t new_val,
        input bus_pkg::strb_t strb
    );
        bus_pkg::data_t res;
        res = old_val;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = new_val[8*i +: 8];
            end
        end
        return res;
    endfunction

    assign wr_off  = wr_addr & ~bus_pkg::LED_MASK;
    assign rd_off  = rd_addr & ~bus_pkg::LED_MASK;
    assign wr_led  = (wr_off == bus_pkg::LED_REG_OFFSET);
    assign wr_scr  = (wr_off == bus_pkg::SCRATCH_OFFSET);
    assign rd_led  = (rd_off == bus_pkg::LED_REG_OFFSET);
    assign rd_scr  = (rd_off == bus_pkg::SCRATCH_OFFSET);
    assign wr_fire = wr_valid & wr_ready;
    assign rd_fire = rd_valid & rd_ready;
    assign led     = led_reg[3:0];

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            wr_ready      <= 1'b0;
            wr_resp_valid <= 1'b0;
            rd_ready      <= 1'b0;
            rd_resp_valid <= 1'b0;
            led_reg       <= '0;
            scratch_reg   <= '0;
        end else begin
            // accept a cycle after valid, never with a response pending
            wr_ready <= wr_valid & ~wr_ready & ~wr_resp_valid;
            rd_ready <= rd_valid & ~rd_ready & ~rd_resp_valid;
            if (wr_fire) begin
                wr_resp_valid <= 1'b1;
            end else if (wr_resp_ready) begin
                wr_resp_valid <= 1'b0;
            end
            if (rd_fire) begin
                rd_resp_valid <= 1'b1;
            end else if (rd_resp_ready) begin
                rd_resp_valid <= 1'b0;
            end
            if (wr_fire && wr_led) begin
                led_reg <= merge(led_reg, wr_data, wr_strb);
            end
            if (wr_fire && wr_scr) begin
                scratch_reg <= merge(scratch_reg, wr_data, wr_strb);
            end
        end
    end

    // response payload, stable until the next accept
    always_ff @(posedge sys_clk) begin
        if (wr_fire) begin
            wr_resp <= (wr_led || wr_scr) ? bus_pkg::RESP_OKAY : bus_pkg::RESP_SLVERR;
        end
        if (rd_fire) begin
            rd_resp <= (rd_led || rd_scr) ? bus_pkg::RESP_OKAY : bus_pkg::RESP_SLVERR;
            rd_data <= rd_led ? led_reg : (rd_scr ? scratch_reg : '0);
        end
    end

endmodule

`default_nettype wire

// ==== src/axi_bus.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_bus (
    input  wire                 sys_clk,
    input  wire                 rst_n,
    // masters
    input  wire bus_pkg::addr_t m0_wr_addr, m0_rd_addr, m1_wr_addr, m1_rd_addr,
    input  wire bus_pkg::data_t m0_wr_data, m1_wr_data,
    input  wire bus_pkg::strb_t m0_wr_strb, m1_wr_strb,
    input  wire                 m0_wr_valid, m0_wr_resp_ready, m0_rd_valid, m0_rd_resp_ready,
    input  wire                 m1_wr_valid, m1_wr_resp_ready, m1_rd_valid, m1_rd_resp_ready,
    output logic                m0_wr_ready, m0_wr_resp_valid, m0_rd_ready, m0_rd_resp_valid,
    output logic                m1_wr_ready, m1_wr_resp_valid, m1_rd_ready, m1_rd_resp_valid,
    output bus_pkg::resp_t      m0_wr_resp, m0_rd_resp, m1_wr_resp, m1_rd_resp,
    output bus_pkg::data_t      m0_rd_data, m1_rd_data,
    // slaves
    output bus_pkg::addr_t      s0_wr_addr, s0_rd_addr,
    output bus_pkg::data_t      s0_wr_data,
    output bus_pkg::strb_t      s0_wr_strb,
    output logic                s0_wr_valid, s0_wr_resp_ready, s0_rd_valid, s0_rd_resp_ready,
    output logic                s1_wr_valid, s1_wr_resp_ready, s1_rd_valid, s1_rd_resp_ready,
    input  wire                 s0_wr_ready, s0_wr_resp_valid, s0_rd_ready, s0_rd_resp_valid,
    input  wire                 s1_wr_ready, s1_wr_resp_valid, s1_rd_ready, s1_rd_resp_valid,
    input  wire bus_pkg::resp_t s0_wr_resp, s0_rd_resp, s1_wr_resp, s1_rd_resp,
    input  wire bus_pkg::data_t s0_rd_data, s1_rd_data
);

    logic [1:0] wr_grant, rd_grant;
    logic wr_busy, rd_busy, wr_done, rd_done;
    logic wr_valid, rd_valid;
    logic wr_s1, rd_s1, wr_s1_q, rd_s1_q;           // 1 = default slave
    logic wr_rsp_valid, rd_rsp_valid, wr_rsp_ready, rd_rsp_ready;
    bus_pkg::addr_t wr_addr, rd_addr;
    bus_pkg::resp_t wr_rsp, rd_rsp;
    bus_pkg::data_t rd_rsp_data;

    bus_arbiter u_wr_arb (
        .sys_clk(sys_clk), .rst_n(rst_n), .req({m1_wr_valid, m0_wr_valid}),
        .done(wr_done), .grant(wr_grant), .busy(wr_busy)
    );

    bus_arbiter u_rd_arb (
        .sys_clk(sys_clk), .rst_n(rst_n), .req({m1_rd_valid, m0_rd_valid}),
        .done(rd_done), .grant(rd_grant), .busy(rd_busy)
    );

    // write request from the granted master
    assign wr_addr     = wr_grant[1] ? m1_wr_addr : m0_wr_addr;
    assign wr_valid    = |(wr_grant & {m1_wr_valid, m0_wr_valid});
    // decode live while the request is up, latched copy for the response
    assign wr_s1       = wr_valid ? ((wr_addr & bus_pkg::LED_MASK) != bus_pkg::LED_BASE)
                                  : wr_s1_q;
    assign s0_wr_addr  = wr_addr;
    assign s0_wr_data  = wr_grant[1] ? m1_wr_data : m0_wr_data;
    assign s0_wr_strb  = wr_grant[1] ? m1_wr_strb : m0_wr_strb;
    assign s0_wr_valid = wr_valid & ~wr_s1;
    assign s1_wr_valid = wr_valid & wr_s1;
    assign m0_wr_ready = wr_grant[0] & (wr_s1 ? s1_wr_ready : s0_wr_ready);
    assign m1_wr_ready = wr_grant[1] & (wr_s1 ? s1_wr_ready : s0_wr_ready);

    // write response back to the owner only
    assign wr_rsp           = wr_s1 ? s1_wr_resp : s0_wr_resp;
    assign wr_rsp_valid     = wr_s1 ? s1_wr_resp_valid : s0_wr_resp_valid;
    assign wr_rsp_ready     = (wr_grant[0] & m0_wr_resp_ready) | (wr_grant[1] & m1_wr_resp_ready);
    assign m0_wr_resp       = wr_rsp;
    assign m1_wr_resp       = wr_rsp;
    assign m0_wr_resp_valid = wr_grant[0] & wr_rsp_valid;
    assign m1_wr_resp_valid = wr_grant[1] & wr_rsp_valid;
    assign s0_wr_resp_ready = wr_rsp_ready & ~wr_s1;
    assign s1_wr_resp_ready = wr_rsp_ready & wr_s1;
    assign wr_done          = wr_busy & wr_rsp_valid & wr_rsp_ready;

    // read request
    assign rd_addr     = rd_grant[1] ? m1_rd_addr : m0_rd_addr;
    assign rd_valid    = |(rd_grant & {m1_rd_valid, m0_rd_valid});
    assign rd_s1       = rd_valid ? ((rd_addr & bus_pkg::LED_MASK) != bus_pkg::LED_BASE)
                                  : rd_s1_q;
    assign s0_rd_addr  = rd_addr;
    assign s0_rd_valid = rd_valid & ~rd_s1;
    assign s1_rd_valid = rd_valid & rd_s1;
    assign m0_rd_ready = rd_grant[0] & (rd_s1 ? s1_rd_ready : s0_rd_ready);
    assign m1_rd_ready = rd_grant[1] & (rd_s1 ? s1_rd_ready : s0_rd_ready);

    // read response
    assign rd_rsp           = rd_s1 ? s1_rd_resp : s0_rd_resp;
    assign rd_rsp_data      = rd_s1 ? s1_rd_data : s0_rd_data;
    assign rd_rsp_valid     = rd_s1 ? s1_rd_resp_valid : s0_rd_resp_valid;
    assign rd_rsp_ready     = (rd_grant[0] & m0_rd_resp_ready) | (rd_grant[1] & m1_rd_resp_ready);
    assign m0_rd_resp       = rd_rsp;
    assign m1_rd_resp       = rd_rsp;
    assign m0_rd_data       = rd_rsp_data;
    assign m1_rd_data       = rd_rsp_data;
    assign m0_rd_resp_valid = rd_grant[0] & rd_rsp_valid;
    assign m1_rd_resp_valid = rd_grant[1] & rd_rsp_valid;
    assign s0_rd_resp_ready = rd_rsp_ready & ~rd_s1;
    assign s1_rd_resp_ready = rd_rsp_ready & rd_s1;
    assign rd_done          = rd_busy & rd_rsp_valid & rd_rsp_ready;

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            wr_s1_q <= 1'b0;
            rd_s1_q <= 1'b0;
        end else begin
            if (wr_valid) begin
                wr_s1_q <= wr_s1;
            end
            if (rd_valid) begin
                rd_s1_q <= rd_s1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/bus_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
    input  wire        sys_clk,
    input  wire        rst_n,
    input  wire  [1:0] req,
    input  wire        done,
    output logic [1:0] grant,
    output logic       busy
);

    bus_pkg::arb_state_t state;
    logic prio;     // master favoured on the next grant
    logic pick;

    // take prio if it asks, otherwise the other one
    assign pick = req[prio] ? prio : ~prio;
    assign busy = (state == bus_pkg::ARB_BUSY);

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            state <= bus_pkg::ARB_IDLE;
            grant <= 2'b00;
            prio  <= 1'b0;
        end else begin
            case (state)
                bus_pkg::ARB_IDLE: begin
                    if (|req) begin
                        state <= bus_pkg::ARB_BUSY;
                        grant <= 2'b01 << pick;
                        prio  <= ~pick;
                    end
                end
                bus_pkg::ARB_BUSY: begin
                    if (done) begin     // response handshake ends the transaction
                        state <= bus_pkg::ARB_IDLE;
                        grant <= 2'b00;
                    end
                end
                default: state <= bus_pkg::ARB_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;
    typedef logic [1:0]  resp_t;
    typedef logic [7:0]  led_t;
    typedef logic [3:0]  btn_t;

    // address map, each slave owns one top nibble
    localparam addr_t LED_BASE       = 32'h2000_0000;
    localparam addr_t LED_MASK       = 32'hF000_0000;
    localparam addr_t LED_REG_OFFSET = 32'h0000_0000;
    localparam addr_t SCRATCH_OFFSET = 32'h0000_0004;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;
    localparam resp_t RESP_DECERR = 2'b11;

    typedef enum logic [2:0] {
        BTN_IDLE,
        BTN_WRITE,
        BTN_WAIT_B,
        BTN_READ,
        BTN_WAIT_R
    } btn_state_t;

    typedef enum logic {
        ARB_IDLE,
        ARB_BUSY
    } arb_state_t;

endpackage

`default_nettype wire
